// File: source/spmc_readback_pkg.sv
`default_nettype none

package spmc_readback_pkg;

    ////////////////////////////////////////////////////////////
    // Word width shared by monitors and GPIO
    ////////////////////////////////////////////////////////////
    localparam int data_w = 32;

    // Decoded readback pages, page_none doubles as idle/unknown
    typedef enum logic [3:0] {
        page_none,
        page_z,
        page_bias,
        page_gvp_bias,
        page_pmd,
        page_z_servo,
        page_amc_fmc,
        page_srcs_mux,
        page_in_mux,
        page_adc,
        page_aux,
        page_uptime,
        page_timing_test,
        page_timing_reset,
        page_version,
        page_sys_state
    } rb_page_e;

    ////////////////////////////////////////////////////////////
    // Firmware readback addresses (decimal, as software uses)
    ////////////////////////////////////////////////////////////
    localparam logic [data_w-1:0] addr_z            = 32'd100001;
    localparam logic [data_w-1:0] addr_bias         = 32'd100002;
    localparam logic [data_w-1:0] addr_gvp_bias     = 32'd100003;
    localparam logic [data_w-1:0] addr_pmd          = 32'd100004;
    localparam logic [data_w-1:0] addr_z_servo      = 32'd100005;
    localparam logic [data_w-1:0] addr_amc_fmc      = 32'd100006;
    localparam logic [data_w-1:0] addr_srcs_mux     = 32'd100010;
    localparam logic [data_w-1:0] addr_in_mux       = 32'd100011;
    localparam logic [data_w-1:0] addr_adc          = 32'd100100; // ADC CH1/CH2
    localparam logic [data_w-1:0] addr_aux          = 32'd100999; // Spare pair
    localparam logic [data_w-1:0] addr_uptime       = 32'd101900;
    localparam logic [data_w-1:0] addr_timing_test  = 32'd101999;
    localparam logic [data_w-1:0] addr_timing_reset = 32'd102000;
    localparam logic [data_w-1:0] addr_version      = 32'd199997;
    localparam logic [data_w-1:0] addr_sys_state    = 32'd199999;

    // Build identification words
    localparam logic [data_w-1:0] version_id   = 32'hEC010099;
    localparam logic [data_w-1:0] version_date = 32'h20250328; // BCD build date

endpackage

`default_nettype wire

// File: source/rb_addr_decode.sv
`default_nettype none

module rb_addr_decode (
    input  wire logic                                    aclk,
    input  wire logic                                    arst_n,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    config_addr, // Raw GPIO address level
    output spmc_readback_pkg::rb_page_e                  page         // Decoded page, 1 cycle late
);

    spmc_readback_pkg::rb_page_e page_next;

    ////////////////////////////////////////////////////////////
    // Address compare
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (config_addr)
            spmc_readback_pkg::addr_z:            page_next = spmc_readback_pkg::page_z;
            spmc_readback_pkg::addr_bias:         page_next = spmc_readback_pkg::page_bias;
            spmc_readback_pkg::addr_gvp_bias:     page_next = spmc_readback_pkg::page_gvp_bias;
            spmc_readback_pkg::addr_pmd:          page_next = spmc_readback_pkg::page_pmd;
            spmc_readback_pkg::addr_z_servo:      page_next = spmc_readback_pkg::page_z_servo;
            spmc_readback_pkg::addr_amc_fmc:      page_next = spmc_readback_pkg::page_amc_fmc;
            spmc_readback_pkg::addr_srcs_mux:     page_next = spmc_readback_pkg::page_srcs_mux;
            spmc_readback_pkg::addr_in_mux:       page_next = spmc_readback_pkg::page_in_mux;
            spmc_readback_pkg::addr_adc:          page_next = spmc_readback_pkg::page_adc;
            spmc_readback_pkg::addr_aux:          page_next = spmc_readback_pkg::page_aux;
            // Housekeeping pages
            spmc_readback_pkg::addr_uptime:       page_next = spmc_readback_pkg::page_uptime;
            spmc_readback_pkg::addr_timing_test:  page_next = spmc_readback_pkg::page_timing_test;
            spmc_readback_pkg::addr_timing_reset: page_next = spmc_readback_pkg::page_timing_reset;
            spmc_readback_pkg::addr_version:      page_next = spmc_readback_pkg::page_version;
            spmc_readback_pkg::addr_sys_state:    page_next = spmc_readback_pkg::page_sys_state;
            default:                              page_next = spmc_readback_pkg::page_none;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Page register
    ////////////////////////////////////////////////////////////
    // Wide compare ends here, downstream sees only the enum
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            page <= spmc_readback_pkg::page_none; // Unknown until first decode
        end
        else
        begin
            page <= page_next;
        end
    end

endmodule

`default_nettype wire

// File: source/coldstart_tracker.sv
`default_nettype none

module coldstart_tracker (
    input  wire logic                                    aclk,
    input  wire logic                                    arst_n,
    input  spmc_readback_pkg::rb_page_e                  page,
    output logic      [spmc_readback_pkg::data_w-1:0]    sys_state, // Counted restarts
    output logic                                         startup    // Set until first version read
);

    logic armed; // Unknown address seen since last state read

    ////////////////////////////////////////////////////////////
    // Cold-start bookkeeping
    ////////////////////////////////////////////////////////////
    // Software visits an unknown address, then reads the state
    // page. Each such pair bumps sys_state once, so a restarted
    // host can tell it is talking to a core that kept running.
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            startup   <= 1'b1;
            armed     <= 1'b0;
            sys_state <= '0;
        end
        else
        begin
            case (page)
                spmc_readback_pkg::page_version:
                begin
                    startup <= 1'b0; // Sticky until next reset
                end
                spmc_readback_pkg::page_none:
                begin
                    armed <= 1'b1;
                end
                spmc_readback_pkg::page_sys_state:
                begin
                    if (armed)
                    begin
                        sys_state <= sys_state + 32'd1; // One count per visit
                        armed     <= 1'b0;
                    end
                end
                default:
                begin
                    // Monitor and timing pages leave state alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/uptime_clock.sv
`default_nettype none

module uptime_clock #(
    parameter int unsigned TICKS_PER_SEC = 125000000 // Fabric clock rate in Hz
) (
    input  wire logic                                    aclk,
    input  wire logic                                    arst_n,
    output logic      [spmc_readback_pkg::data_w-1:0]    sec_count,  // Whole seconds
    output logic      [spmc_readback_pkg::data_w-1:0]    tick_count  // Ticks left in second
);

    // Reload value for the fraction counter
    localparam logic [spmc_readback_pkg::data_w-1:0] tick_reload = TICKS_PER_SEC - 1;

    ////////////////////////////////////////////////////////////
    // Monotonic uptime
    ////////////////////////////////////////////////////////////
    // About 136 years before sec_count wraps at 125 MHz
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sec_count  <= '0;
            tick_count <= '0; // First edge reloads, sec becomes 1
        end
        else if (tick_count == '0)
        begin
            tick_count <= tick_reload;
            sec_count  <= sec_count + 32'd1;
        end
        else
        begin
            tick_count <= tick_count - 32'd1; // Count down the fraction
        end
    end

endmodule

`default_nettype wire

// File: source/readback_mux.sv
`default_nettype none

module readback_mux #(
    parameter int unsigned TICKS_PER_SEC = 125000000
) (
    input  wire logic                                    aclk,
    input  wire logic                                    arst_n,
    input  spmc_readback_pkg::rb_page_e                  page,

    // Z generator
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_gvp_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_slope_mon,
    // Bias chain
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_sum_mon, // U0 + GVP + mod
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_u0_mon,  // Set value
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_gvp_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_mod_mon, // Lock-in etc
    // PMD outputs
    input  wire logic [spmc_readback_pkg::data_w-1:0]    pmd_da_5a,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    pmd_da_6b,
    // Z servo
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_servo_a,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_servo_b,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    gvp_amc,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    gvp_fmc,
    // Multiplexer selects
    input  wire logic [spmc_readback_pkg::data_w-1:0]    srcs_mux_sel,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    in_mux_sel,
    // ADC and spare
    input  wire logic [spmc_readback_pkg::data_w-1:0]    adc_ch1,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    adc_ch2,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    aux_a,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    aux_b,
    // Housekeeping
    input  wire logic [spmc_readback_pkg::data_w-1:0]    sec_count,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    tick_count,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    sys_state,
    input  wire logic                                    startup,

    output logic      [spmc_readback_pkg::data_w-1:0]    gpio_data_a,
    output logic      [spmc_readback_pkg::data_w-1:0]    gpio_data_b
);

    localparam int dw = spmc_readback_pkg::data_w;

    // Clock rate word for the timing test page
    localparam logic [dw-1:0] ticks_word = TICKS_PER_SEC;

    ////////////////////////////////////////////////////////////
    // Output word registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gpio_data_a <= '0;
            gpio_data_b <= '0;
        end
        else
        begin
            case (page)
                // Live monitor pairs
                spmc_readback_pkg::page_z:
                begin
                    gpio_data_a <= z_gvp_mon;
                    gpio_data_b <= z_slope_mon;
                end
                spmc_readback_pkg::page_bias:
                begin
                    gpio_data_a <= bias_sum_mon;
                    gpio_data_b <= bias_u0_mon;
                end
                spmc_readback_pkg::page_gvp_bias:
                begin
                    gpio_data_a <= bias_gvp_mon;
                    gpio_data_b <= bias_mod_mon;
                end
                spmc_readback_pkg::page_pmd:
                begin
                    gpio_data_a <= pmd_da_5a;
                    gpio_data_b <= pmd_da_6b;
                end
                spmc_readback_pkg::page_z_servo:
                begin
                    gpio_data_a <= z_servo_a;
                    gpio_data_b <= z_servo_b;
                end
                spmc_readback_pkg::page_amc_fmc:
                begin
                    gpio_data_a <= gvp_amc;
                    gpio_data_b <= gvp_fmc;
                end
                spmc_readback_pkg::page_srcs_mux:
                begin
                    gpio_data_a <= srcs_mux_sel;
                    gpio_data_b <= in_mux_sel;
                end
                spmc_readback_pkg::page_in_mux:
                begin
                    gpio_data_a <= in_mux_sel;
                    gpio_data_b <= '0; // Single-word page
                end
                spmc_readback_pkg::page_adc:
                begin
                    gpio_data_a <= adc_ch1;
                    gpio_data_b <= adc_ch2;
                end
                spmc_readback_pkg::page_aux:
                begin
                    gpio_data_a <= aux_a;
                    gpio_data_b <= aux_b;
                end
                // Housekeeping pages
                spmc_readback_pkg::page_uptime:
                begin
                    gpio_data_a <= sec_count;
                    gpio_data_b <= tick_count;
                end
                spmc_readback_pkg::page_timing_test:
                begin
                    gpio_data_a <= ticks_word;
                    gpio_data_b <= gpio_data_a; // Lags A by one cycle
                end
                spmc_readback_pkg::page_timing_reset:
                begin
                    gpio_data_a <= '0;
                    gpio_data_b <= '0;
                end
                spmc_readback_pkg::page_version:
                begin
                    gpio_data_a <= spmc_readback_pkg::version_id;
                    gpio_data_b <= spmc_readback_pkg::version_date;
                end
                spmc_readback_pkg::page_sys_state:
                begin
                    gpio_data_a <= sys_state; // Value before this edge
                    gpio_data_b <= {{(dw-1){1'b0}}, startup};
                end
                default:
                begin
                    // Free-running pattern, shows the link is alive
                    gpio_data_a <= gpio_data_a + 32'd1;
                    gpio_data_b <= gpio_data_a + 32'd13;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/spmc_readback_top.sv
`default_nettype none

module spmc_readback_top #(
    parameter int unsigned TICKS_PER_SEC = 125000000
) (
    input  wire logic                                    aclk,
    input  wire logic                                    arst_n,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    config_addr,

    // Monitor inputs from the surrounding core
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_gvp_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_slope_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_sum_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_u0_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_gvp_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    bias_mod_mon,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    pmd_da_5a,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    pmd_da_6b,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_servo_a,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    z_servo_b,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    gvp_amc,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    gvp_fmc,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    srcs_mux_sel,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    in_mux_sel,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    adc_ch1,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    adc_ch2,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    aux_a,
    input  wire logic [spmc_readback_pkg::data_w-1:0]    aux_b,

    // GPIO data words and uptime taps
    output wire logic [spmc_readback_pkg::data_w-1:0]    gpio_data_a,
    output wire logic [spmc_readback_pkg::data_w-1:0]    gpio_data_b,
    output wire logic [spmc_readback_pkg::data_w-1:0]    clock_sec,
    output wire logic [spmc_readback_pkg::data_w-1:0]    clock_ticks
);

    spmc_readback_pkg::rb_page_e                 page;      // Shared by tracker and mux
    logic [spmc_readback_pkg::data_w-1:0]        sys_state;
    logic                                        startup;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////
    rb_addr_decode u_decode (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .config_addr (config_addr),
        .page        (page)
    );

    ////////////////////////////////////////////////////////////
    // Processing
    ////////////////////////////////////////////////////////////
    coldstart_tracker u_tracker (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .page      (page),
        .sys_state (sys_state),
        .startup   (startup)
    );

    uptime_clock #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_uptime (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .sec_count  (clock_sec),   // Also feeds the mux
        .tick_count (clock_ticks)
    );

    ////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////
    readback_mux #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_mux (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .page         (page),
        .z_gvp_mon    (z_gvp_mon),
        .z_slope_mon  (z_slope_mon),
        .bias_sum_mon (bias_sum_mon),
        .bias_u0_mon  (bias_u0_mon),
        .bias_gvp_mon (bias_gvp_mon),
        .bias_mod_mon (bias_mod_mon),
        .pmd_da_5a    (pmd_da_5a),
        .pmd_da_6b    (pmd_da_6b),
        .z_servo_a    (z_servo_a),
        .z_servo_b    (z_servo_b),
        .gvp_amc      (gvp_amc),
        .gvp_fmc      (gvp_fmc),
        .srcs_mux_sel (srcs_mux_sel),
        .in_mux_sel   (in_mux_sel),
        .adc_ch1      (adc_ch1),
        .adc_ch2      (adc_ch2),
        .aux_a        (aux_a),
        .aux_b        (aux_b),
        .sec_count    (clock_sec),
        .tick_count   (clock_ticks),
        .sys_state    (sys_state),
        .startup      (startup),
        .gpio_data_a  (gpio_data_a),
        .gpio_data_b  (gpio_data_b)
    );

endmodule

`default_nettype wire

// File: tests/tb_spmc_readback.sv
`default_nettype none

module tb_spmc_readback;

    localparam logic [31:0] tb_ticks  = 32'd20; // Small clock rate for a fast second roll
    localparam int          cmp_limit = 20;     // Cycles a compare may take

    // Monitor values in the order of the port list below
    typedef logic [31:0] mon_arr_t [18];

    logic                        aclk;
    logic                        arst_n;
    logic [31:0]                 config_addr;
    mon_arr_t                    mon;
    logic [31:0]                 gpio_data_a;
    logic [31:0]                 gpio_data_b;
    logic [31:0]                 clock_sec;
    logic [31:0]                 clock_ticks;

    int                          check_count;
    int                          error_count;
    logic [31:0]                 cycle_count;   // Edges since reset release
    logic                        timed_out;     // Set once a compare overran

    // Tracker model
    logic [31:0]                 exp_state;
    logic                        exp_startup;
    logic                        exp_armed;

    // Stimulus to compare handshake
    logic                        cmp_req;
    logic                        cmp_done;
    string                       cmp_name;
    spmc_readback_pkg::rb_page_e cmp_page;

    // Last uptime read seen by the compare process
    logic [31:0]                 up_lin_seen;
    logic [31:0]                 up_cyc_seen;
    logic [31:0]                 first_lin;
    logic [31:0]                 first_cyc;

    spmc_readback_top #(
        .TICKS_PER_SEC (tb_ticks)
    ) u_dut (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .config_addr  (config_addr),
        .z_gvp_mon    (mon[0]),
        .z_slope_mon  (mon[1]),
        .bias_sum_mon (mon[2]),
        .bias_u0_mon  (mon[3]),
        .bias_gvp_mon (mon[4]),
        .bias_mod_mon (mon[5]),
        .pmd_da_5a    (mon[6]),
        .pmd_da_6b    (mon[7]),
        .z_servo_a    (mon[8]),
        .z_servo_b    (mon[9]),
        .gvp_amc      (mon[10]),
        .gvp_fmc      (mon[11]),
        .srcs_mux_sel (mon[12]),
        .in_mux_sel   (mon[13]),
        .adc_ch1      (mon[14]),
        .adc_ch2      (mon[15]),
        .aux_a        (mon[16]),
        .aux_b        (mon[17]),
        .gpio_data_a  (gpio_data_a),
        .gpio_data_b  (gpio_data_b),
        .clock_sec    (clock_sec),
        .clock_ticks  (clock_ticks)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk; // Period 100
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////
    // Expected {A, B} for every page with a fixed answer
    function automatic logic [63:0] ref_words(
        input spmc_readback_pkg::rb_page_e pg,
        input mon_arr_t                    m,
        input logic [31:0]                 st_count,
        input logic                        st_startup,
        input logic [31:0]                 up_lin
    );
        case (pg)
            spmc_readback_pkg::page_z:            return {m[0], m[1]};
            spmc_readback_pkg::page_bias:         return {m[2], m[3]};
            spmc_readback_pkg::page_gvp_bias:     return {m[4], m[5]};
            spmc_readback_pkg::page_pmd:          return {m[6], m[7]};
            spmc_readback_pkg::page_z_servo:      return {m[8], m[9]};
            spmc_readback_pkg::page_amc_fmc:      return {m[10], m[11]};
            spmc_readback_pkg::page_srcs_mux:     return {m[12], m[13]};
            spmc_readback_pkg::page_in_mux:       return {m[13], 32'd0}; // B unused
            spmc_readback_pkg::page_adc:          return {m[14], m[15]};
            spmc_readback_pkg::page_aux:          return {m[16], m[17]};
            spmc_readback_pkg::page_uptime:
                return {up_lin / tb_ticks, tb_ticks - 32'd1 - (up_lin % tb_ticks)};
            spmc_readback_pkg::page_timing_test:  return {tb_ticks, tb_ticks};
            spmc_readback_pkg::page_timing_reset: return 64'd0;
            spmc_readback_pkg::page_version:      return {32'hEC010099, 32'h20250328};
            spmc_readback_pkg::page_sys_state:    return {st_count, 31'd0, st_startup};
            default:                              return 64'd0;
        endcase
    endfunction

    // Seconds and remaining ticks folded into one tick count
    function automatic logic [31:0] lin_count(input logic [31:0] sec, input logic [31:0] ticks);
        return sec * tb_ticks + (tb_ticks - 32'd1) - ticks;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act)
        begin
            error_count++;
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_page(
        input string                       name,
        input spmc_readback_pkg::rb_page_e exp,
        input spmc_readback_pkg::rb_page_e act
    );
        check_count++;
        if (exp !== act)
        begin
            error_count++;
            $display("[ERROR] %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Uptime taps and compare process
    ////////////////////////////////////////////////////////////
    always @(posedge aclk)
    begin
        if (!arst_n)
            cycle_count <= 32'd0;
        else
            cycle_count <= cycle_count + 32'd1;
    end

    // Taps advance one tick count per edge from 19 at reset
    always @(negedge aclk)
    begin
        if (cycle_count != 32'd0)
        begin
            check_word("uptime taps", cycle_count + tb_ticks - 32'd1,
                       lin_count(clock_sec, clock_ticks));
        end
    end

    initial
    begin : compare_proc
        logic [63:0] exp_pair;
        logic [31:0] prev_a;
        forever
        begin
            @(posedge aclk);
            if (cmp_req)
            begin
                cmp_req = 1'b0;
                @(posedge aclk);
                @(posedge aclk);
                @(negedge aclk); // Third cycle after the address change
                check_page({cmp_name, " page"}, cmp_page, u_dut.page);
                if (cmp_page == spmc_readback_pkg::page_none)
                begin
                    check_word({cmp_name, " b"}, gpio_data_a + 32'd12, gpio_data_b);
                    repeat (6)
                    begin
                        prev_a = gpio_data_a;
                        @(negedge aclk);
                        check_word({cmp_name, " a step"}, prev_a + 32'd1, gpio_data_a);
                        check_word({cmp_name, " b"}, gpio_data_a + 32'd12, gpio_data_b);
                    end
                end
                else
                begin
                    // Mux holds the taps from one edge back
                    exp_pair = ref_words(cmp_page, mon, exp_state, exp_startup,
                                         cycle_count + tb_ticks - 32'd2);
                    check_word({cmp_name, " a"}, exp_pair[63:32], gpio_data_a);
                    check_word({cmp_name, " b"}, exp_pair[31:0], gpio_data_b);
                    if (cmp_page == spmc_readback_pkg::page_uptime)
                    begin
                        up_lin_seen = lin_count(gpio_data_a, gpio_data_b);
                        up_cyc_seen = cycle_count;
                    end
                end
                cmp_done = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    // One address visit with new monitor values and a settled compare
    task automatic visit(
        input logic [31:0]                 addr,
        input spmc_readback_pkg::rb_page_e pg,
        input string                       name
    );
        int waited;
        if (timed_out)
        begin
            return;
        end
        waited = 0;
        @(negedge aclk);
        config_addr = addr;
        foreach (mon[i])
        begin
            mon[i] = $urandom;
        end
        case (pg)
            spmc_readback_pkg::page_version:   exp_startup = 1'b0; // Sticky clear
            spmc_readback_pkg::page_none:      exp_armed   = 1'b1;
            spmc_readback_pkg::page_sys_state:
            begin
                if (exp_armed)
                begin
                    exp_state = exp_state + 32'd1;
                    exp_armed = 1'b0;
                end
            end
            default:
            begin
            end
        endcase
        cmp_page = pg;
        cmp_name = name;
        cmp_done = 1'b0;
        cmp_req  = 1'b1;
        while (!cmp_done && waited < cmp_limit)
        begin
            @(posedge aclk);
            waited++;
        end
        if (!cmp_done)
        begin
            $display("compare of %s did not finish within %0d cycles", name, cmp_limit);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    initial
    begin : stimulus
        void'($urandom(24));
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;
        arst_n      = 1'b0;
        config_addr = spmc_readback_pkg::addr_sys_state;
        foreach (mon[i])
        begin
            mon[i] = 32'd0;
        end
        cmp_req     = 1'b0;
        cmp_done    = 1'b0;
        cmp_name    = "";
        cmp_page    = spmc_readback_pkg::page_none;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;

        // State page is up two cycles after release
        @(posedge aclk);
        @(posedge aclk);
        @(negedge aclk);
        check_word("reset state a", 32'd0, gpio_data_a);
        check_word("reset state b", 32'd1, gpio_data_b);
        // Reset page is page_none so that read already counted once
        exp_state   = 32'd1;
        exp_armed   = 1'b0;
        exp_startup = 1'b1;
        visit(spmc_readback_pkg::addr_sys_state, spmc_readback_pkg::page_sys_state, "state");
        visit(spmc_readback_pkg::addr_sys_state, spmc_readback_pkg::page_sys_state, "state again");

        // Live monitor pairs twice with fresh values
        repeat (2)
        begin
            visit(spmc_readback_pkg::addr_z,        spmc_readback_pkg::page_z,        "z");
            visit(spmc_readback_pkg::addr_bias,     spmc_readback_pkg::page_bias,     "bias");
            visit(spmc_readback_pkg::addr_gvp_bias, spmc_readback_pkg::page_gvp_bias, "gvp bias");
            visit(spmc_readback_pkg::addr_pmd,      spmc_readback_pkg::page_pmd,      "pmd");
            visit(spmc_readback_pkg::addr_z_servo,  spmc_readback_pkg::page_z_servo,  "z servo");
            visit(spmc_readback_pkg::addr_amc_fmc,  spmc_readback_pkg::page_amc_fmc,  "amc fmc");
            visit(spmc_readback_pkg::addr_srcs_mux, spmc_readback_pkg::page_srcs_mux, "srcs mux");
            visit(spmc_readback_pkg::addr_in_mux,   spmc_readback_pkg::page_in_mux,   "in mux");
            visit(spmc_readback_pkg::addr_adc,      spmc_readback_pkg::page_adc,      "adc");
            visit(spmc_readback_pkg::addr_aux,      spmc_readback_pkg::page_aux,      "aux");
        end

        // Constant pages
        visit(spmc_readback_pkg::addr_version, spmc_readback_pkg::page_version, "version");
        visit(spmc_readback_pkg::addr_timing_reset, spmc_readback_pkg::page_timing_reset,
              "timing reset");
        visit(spmc_readback_pkg::addr_timing_test, spmc_readback_pkg::page_timing_test,
              "timing test");
        visit(spmc_readback_pkg::addr_sys_state, spmc_readback_pkg::page_sys_state,
              "state after version");

        // Test pattern and restart counting
        visit(32'd100000, spmc_readback_pkg::page_none, "pattern low");
        visit(spmc_readback_pkg::addr_sys_state, spmc_readback_pkg::page_sys_state, "count 2");
        visit(spmc_readback_pkg::addr_sys_state, spmc_readback_pkg::page_sys_state, "hold 2");
        visit(32'hFFFFFFFF, spmc_readback_pkg::page_none, "pattern high");
        visit(spmc_readback_pkg::addr_adc, spmc_readback_pkg::page_adc, "adc between");
        visit(spmc_readback_pkg::addr_sys_state, spmc_readback_pkg::page_sys_state, "count 3");

        // Two uptime reads whose tick counts differ by the cycles between
        visit(spmc_readback_pkg::addr_uptime, spmc_readback_pkg::page_uptime, "uptime 1");
        first_lin = up_lin_seen;
        first_cyc = up_cyc_seen;
        visit(spmc_readback_pkg::addr_aux, spmc_readback_pkg::page_aux, "aux between");
        visit(spmc_readback_pkg::addr_z, spmc_readback_pkg::page_z, "z between");
        visit(spmc_readback_pkg::addr_uptime, spmc_readback_pkg::page_uptime, "uptime 2");
        check_word("uptime delta", up_cyc_seen - first_cyc, up_lin_seen - first_lin);

        finish_run();
    end

endmodule

`default_nettype wire

// File: filelist.f
source/spmc_readback_pkg.sv
source/rb_addr_decode.sv
source/coldstart_tracker.sv
source/uptime_clock.sv
source/readback_mux.sv
source/spmc_readback_top.sv
tests/tb_spmc_readback.sv

// File: Makefile
# Verilator build and run of the readback testbench

VERILATOR ?= verilator
TOP       ?= tb_spmc_readback
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
